// File: src.f
design/axi_remap_pkg.sv
design/axi_map_rule_table.sv
design/axi_addr_map_lookup.sv
design/axi_modify_address.sv
design/axi_addr_remap_top.sv
verification/tb_axi_addr_remap.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the AXI address remap testbench with Verilator
set -e

# Work from the project root so the paths in src.f resolve
cd "$(dirname "$0")"

# --binary builds a runnable model with timing support
# --assert enables immediate and concurrent assertions
verilator --binary --assert \
  --top-module tb_axi_addr_remap \
  -f src.f \
  -o tb_axi_addr_remap

# A $fatal in the testbench gives a non-zero exit status
./obj_dir/tb_axi_addr_remap

// File: verification/tb_axi_addr_remap.sv
// AXI address remap testbench
module tb_axi_addr_remap;

  import axi_remap_pkg::*;

  localparam int unsigned NumRules = 4;
  localparam int ClkPeriod     = 100;
  localparam int ResetCycles   = 16;
  localparam int NumRows       = 14;
  localparam int TimeoutCycles = ResetCycles + 4 * NumRows + 50;

  // One table entry, a rule write or a transaction
  typedef struct packed {
    logic       is_cfg;
    logic [1:0] idx;
    map_rule_t  rule;
    addr_t      aw_addr;
    addr_t      ar_addr;
    // Manager side readies, in the order aw, ar, w
    logic [2:0] readies;
    // Cycles the transaction is held, stalls use more than one
    logic [1:0] hold;
    addr_t      exp_aw_addr;
    addr_t      exp_ar_addr;
    logic       exp_aw_miss;
    logic       exp_ar_miss;
    logic [2:0] exp_readies;
  } row_t;

  logic      clk;
  logic      rst_n;
  axi_req_t  sbr_req;
  axi_rsp_t  sbr_rsp;
  axi_req_t  mgr_req;
  axi_rsp_t  mgr_rsp;
  logic      cfg_we;
  logic [1:0] cfg_idx;
  map_rule_t cfg_rule;
  logic      aw_miss;
  logic      ar_miss;

  integer seed;
  int     cycle_count;
  row_t   rows [NumRows];

  axi_addr_remap_top #(
    .NumRules   (NumRules)
  ) axi_addr_remap_top_inst (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .sbr_req_i  (sbr_req),
    .sbr_rsp_o  (sbr_rsp),
    .mgr_req_o  (mgr_req),
    .mgr_rsp_i  (mgr_rsp),
    .cfg_we_i   (cfg_we),
    .cfg_idx_i  (cfg_idx),
    .cfg_rule_i (cfg_rule),
    .aw_miss_o  (aw_miss),
    .ar_miss_o  (ar_miss)
  );

  // Free running clock
  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Ends the run with the fail message
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  // Hard limit on run length
  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count > TimeoutCycles) begin
        stop_run($sformatf("Timeout: run exceeded %0d clock cycles", TimeoutCycles));
      end
    end
  end

  function automatic row_t cfg_row(input logic [1:0] idx, input logic valid,
                                   input addr_t base, input addr_t mask,
                                   input addr_t target);
    row_t r;
    r             = '0;
    r.is_cfg      = 1'b1;
    r.idx         = idx;
    r.rule.valid  = valid;
    r.rule.base   = base;
    r.rule.mask   = mask;
    r.rule.target = target;
    return r;
  endfunction

  function automatic row_t txn_row(input addr_t aw_addr, input addr_t ar_addr,
                                   input logic [2:0] readies, input logic [1:0] hold,
                                   input addr_t exp_aw, input addr_t exp_ar,
                                   input logic aw_m, input logic ar_m);
    row_t r;
    r             = '0;
    r.aw_addr     = aw_addr;
    r.ar_addr     = ar_addr;
    r.readies     = readies;
    r.hold        = hold;
    r.exp_aw_addr = exp_aw;
    r.exp_ar_addr = exp_ar;
    r.exp_aw_miss = aw_m;
    r.exp_ar_miss = ar_m;
    // Readies come back from the manager side unchanged
    r.exp_readies = readies;
    return r;
  endfunction

  task automatic fill_table();
    // No rules yet, everything misses
    rows[0]  = txn_row(32'h1000_0040, 32'h2000_0080, 3'b111, 2'd1,
                       32'h1000_0040, 32'h2000_0080, 1'b1, 1'b1);
    rows[1]  = cfg_row(2'd0, 1'b1, 32'h1000_0000, 32'hF000_0000, 32'h8000_0000);
    rows[2]  = txn_row(32'h1000_0040, 32'h2000_0080, 3'b111, 2'd1,
                       32'h8000_0040, 32'h2000_0080, 1'b0, 1'b1);
    rows[3]  = cfg_row(2'd1, 1'b1, 32'h2000_0000, 32'hFFF0_0000, 32'h9010_0000);
    // AW and AR hit different rules in the same cycle
    rows[4]  = txn_row(32'h1234_5678, 32'h2004_1234, 3'b111, 2'd1,
                       32'h8234_5678, 32'h9014_1234, 1'b0, 1'b0);
    rows[5]  = cfg_row(2'd2, 1'b1, 32'h2000_0000, 32'hF000_0000, 32'hA000_0000);
    // AR matches rules 1 and 2, rule 1 wins
    rows[6]  = txn_row(32'h2FF0_0010, 32'h2004_1234, 3'b111, 2'd1,
                       32'hAFF0_0010, 32'h9014_1234, 1'b0, 1'b0);
    rows[7]  = cfg_row(2'd3, 1'b1, 32'h1000_0000, 32'hFF00_0000, 32'hC000_0000);
    // Full stall for three cycles, AW also matches rule 3 but rule 0 wins
    rows[8]  = txn_row(32'h1000_0040, 32'h3000_0000, 3'b000, 2'd3,
                       32'h8000_0040, 32'h3000_0000, 1'b0, 1'b1);
    // Only AR stalled
    rows[9]  = txn_row(32'h2010_0008, 32'h1000_0FFC, 3'b101, 2'd2,
                       32'hA010_0008, 32'h8000_0FFC, 1'b0, 1'b0);
    rows[10] = cfg_row(2'd0, 1'b0, 32'h0, 32'h0, 32'h0);
    // Rule 0 gone, AW falls to rule 3 and AR misses
    rows[11] = txn_row(32'h1000_0040, 32'h1100_0000, 3'b111, 2'd1,
                       32'hC000_0040, 32'h1100_0000, 1'b0, 1'b1);
    rows[12] = cfg_row(2'd3, 1'b0, 32'h0, 32'h0, 32'h0);
    rows[13] = txn_row(32'h1000_0040, 32'h2004_1234, 3'b111, 2'd1,
                       32'h1000_0040, 32'h9014_1234, 1'b1, 1'b0);
  endtask

  // Compare DUT outputs with one transaction row
  task automatic check_txn(input row_t r, input axi_req_t req, input axi_rsp_t rsp);
    axi_req_t   exp_req;
    logic [2:0] got_readies;
    exp_req         = req;
    exp_req.aw.addr = r.exp_aw_addr;
    exp_req.ar.addr = r.exp_ar_addr;
    got_readies     = {sbr_rsp.aw_ready, sbr_rsp.ar_ready, sbr_rsp.w_ready};
    assert (mgr_req.aw.addr == r.exp_aw_addr) else
      stop_run($sformatf("FAILED at time %0t: AW address %h, expected %h",
                         $time, mgr_req.aw.addr, r.exp_aw_addr));
    assert (mgr_req.ar.addr == r.exp_ar_addr) else
      stop_run($sformatf("FAILED at time %0t: AR address %h, expected %h",
                         $time, mgr_req.ar.addr, r.exp_ar_addr));
    assert (aw_miss == r.exp_aw_miss) else
      stop_run($sformatf("FAILED at time %0t: AW miss %b, expected %b",
                         $time, aw_miss, r.exp_aw_miss));
    assert (ar_miss == r.exp_ar_miss) else
      stop_run($sformatf("FAILED at time %0t: AR miss %b, expected %b",
                         $time, ar_miss, r.exp_ar_miss));
    // All other request fields pass through
    assert (mgr_req == exp_req) else
      stop_run($sformatf("FAILED at time %0t: manager request fields differ", $time));
    assert (got_readies == r.exp_readies) else
      stop_run($sformatf("FAILED at time %0t: readies %b, expected %b",
                         $time, got_readies, r.exp_readies));
    assert (sbr_rsp == rsp) else
      stop_run($sformatf("FAILED at time %0t: subordinate response differs", $time));
  endtask

  // Called on a falling edge
  task automatic write_rule(input row_t r);
    cfg_we   = 1'b1;
    cfg_idx  = r.idx;
    cfg_rule = r.rule;
    @(negedge clk);
    cfg_we   = 1'b0;
  endtask

  // Called on a falling edge, checks a quarter period later
  task automatic run_txn(input row_t r);
    axi_req_t req;
    axi_rsp_t rsp;
    req = '0;
    rsp = '0;
    // Write address, fixed controls with random ID and length
    req.aw.id     = id_t'($random(seed));
    req.aw.addr   = r.aw_addr;
    req.aw.len    = len_t'($random(seed));
    req.aw.size   = 3'd3;
    req.aw.burst  = 2'b01;
    req.aw.cache  = 4'h3;
    req.aw.prot   = 3'b010;
    req.aw.qos    = 4'h5;
    req.aw.region = 4'hA;
    req.aw.user   = 1'b1;
    req.aw_valid  = 1'b1;
    // Random write data
    req.w.data    = {32'($random(seed)), 32'($random(seed))};
    req.w.strb    = '1;
    req.w.last    = 1'b1;
    req.w_valid   = 1'b1;
    req.b_ready   = 1'b1;
    // Read address
    req.ar.id     = id_t'($random(seed));
    req.ar.addr   = r.ar_addr;
    req.ar.len    = len_t'($random(seed));
    req.ar.size   = 3'd2;
    req.ar.burst  = 2'b10;
    req.ar.lock   = 1'b1;
    req.ar.cache  = 4'hF;
    req.ar.prot   = 3'b101;
    req.ar.qos    = 4'hC;
    req.ar.region = 4'h6;
    req.ar_valid  = 1'b1;
    req.r_ready   = 1'b1;
    // Manager side readies and responses
    rsp.aw_ready  = r.readies[2];
    rsp.ar_ready  = r.readies[1];
    rsp.w_ready   = r.readies[0];
    rsp.b_valid   = 1'b1;
    rsp.b.id      = id_t'($random(seed));
    rsp.b.resp    = 2'b00;
    rsp.r_valid   = 1'b1;
    rsp.r.id      = id_t'($random(seed));
    rsp.r.data    = {32'($random(seed)), 32'($random(seed))};
    rsp.r.last    = 1'b1;
    sbr_req = req;
    mgr_rsp = rsp;
    // Inputs held for the stall, result rechecked each cycle
    for (int c = 0; c < int'(r.hold); c++) begin
      if (c > 0) begin
        @(negedge clk);
      end
      #(ClkPeriod / 4);
      check_txn(r, req, rsp);
    end
  endtask

  initial begin
    seed     = 32'h5870_796d;
    rst_n    = 1'b0;
    sbr_req  = '0;
    mgr_rsp  = '0;
    cfg_we   = 1'b0;
    cfg_idx  = '0;
    cfg_rule = '0;
    fill_table();
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < NumRows; i++) begin
      @(negedge clk);
      if (rows[i].is_cfg) begin
        write_rule(rows[i]);
      end else begin
        run_txn(rows[i]);
      end
    end
    $display("Test OK");
    $finish;
  end

endmodule

// File: design/axi_addr_remap_top.sv
// AXI address remap stage
module axi_addr_remap_top #(
  parameter int unsigned NumRules = axi_remap_pkg::NumRulesDefault
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Subordinate port
  input  axi_remap_pkg::axi_req_t       sbr_req_i,
  output axi_remap_pkg::axi_rsp_t       sbr_rsp_o,
  // Manager port
  output axi_remap_pkg::axi_req_t       mgr_req_o,
  input  axi_remap_pkg::axi_rsp_t       mgr_rsp_i,
  // Rule config strobe
  input  logic                          cfg_we_i,
  input  logic [$clog2(NumRules)-1:0]   cfg_idx_i,
  input  axi_remap_pkg::map_rule_t      cfg_rule_i,
  // Per-channel miss levels
  output logic                          aw_miss_o,
  output logic                          ar_miss_o
);

  import axi_remap_pkg::*;

  // Rule set shared by both lookups
  map_rule_t [NumRules-1:0] rules;
  // Translated addresses
  addr_t aw_addr;
  addr_t ar_addr;

  // Programmable rules
  axi_map_rule_table #(
    .NumRules   (NumRules)
  ) axi_map_rule_table_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cfg_we_i   (cfg_we_i),
    .cfg_idx_i  (cfg_idx_i),
    .cfg_rule_i (cfg_rule_i),
    .rules_o    (rules)
  );

  // Write address lookup
  axi_addr_map_lookup #(
    .NumRules (NumRules)
  ) aw_lookup_inst (
    .addr_i   (sbr_req_i.aw.addr),
    .rules_i  (rules),
    .addr_o   (aw_addr),
    .miss_o   (aw_miss_o)
  );

  // Read address lookup, runs alongside AW
  axi_addr_map_lookup #(
    .NumRules (NumRules)
  ) ar_lookup_inst (
    .addr_i   (sbr_req_i.ar.addr),
    .rules_i  (rules),
    .addr_o   (ar_addr),
    .miss_o   (ar_miss_o)
  );

  // Same request type on both ports here
  axi_modify_address #(
    .sbr_port_axi_req_t (axi_req_t),
    .mgr_addr_t         (addr_t),
    .mgr_port_axi_req_t (axi_req_t),
    .axi_rsp_t          (axi_rsp_t)
  ) axi_modify_address_inst (
    .sbr_port_req_i     (sbr_req_i),
    .sbr_port_rsp_o     (sbr_rsp_o),
    .mgr_aw_addr_i      (aw_addr),
    .mgr_ar_addr_i      (ar_addr),
    .mgr_port_req_o     (mgr_req_o),
    .mgr_port_rsp_i     (mgr_rsp_i)
  );

endmodule

// File: design/axi_modify_address.sv
// AXI4 address substitution
module axi_modify_address #(
  // Subordinate port request type
  parameter type sbr_port_axi_req_t = logic,
  // Manager port address type
  parameter type mgr_addr_t = logic,
  // Manager port request type
  parameter type mgr_port_axi_req_t = logic,
  // Response type, same on both ports
  parameter type axi_rsp_t = logic
) (
  input  sbr_port_axi_req_t sbr_port_req_i,
  output axi_rsp_t          sbr_port_rsp_o,
  // AW address for the manager side, held stable during a pending AW
  input  mgr_addr_t         mgr_aw_addr_i,
  // AR address for the manager side, held stable during a pending AR
  input  mgr_addr_t         mgr_ar_addr_i,
  output mgr_port_axi_req_t mgr_port_req_o,
  input  axi_rsp_t          mgr_port_rsp_i
);

  // Request path, field by field so the two request types may differ
  always_comb begin
    mgr_port_req_o = '0;

    // Write address, only addr is replaced
    mgr_port_req_o.aw.id     = sbr_port_req_i.aw.id;
    mgr_port_req_o.aw.addr   = mgr_aw_addr_i;
    mgr_port_req_o.aw.len    = sbr_port_req_i.aw.len;
    mgr_port_req_o.aw.size   = sbr_port_req_i.aw.size;
    mgr_port_req_o.aw.burst  = sbr_port_req_i.aw.burst;
    mgr_port_req_o.aw.lock   = sbr_port_req_i.aw.lock;
    mgr_port_req_o.aw.cache  = sbr_port_req_i.aw.cache;
    mgr_port_req_o.aw.prot   = sbr_port_req_i.aw.prot;
    mgr_port_req_o.aw.qos    = sbr_port_req_i.aw.qos;
    mgr_port_req_o.aw.region = sbr_port_req_i.aw.region;
    mgr_port_req_o.aw.atop   = sbr_port_req_i.aw.atop;
    mgr_port_req_o.aw.user   = sbr_port_req_i.aw.user;
    mgr_port_req_o.aw_valid  = sbr_port_req_i.aw_valid;

    // Write data untouched
    mgr_port_req_o.w       = sbr_port_req_i.w;
    mgr_port_req_o.w_valid = sbr_port_req_i.w_valid;
    mgr_port_req_o.b_ready = sbr_port_req_i.b_ready;

    // Read address, only addr is replaced
    mgr_port_req_o.ar.id     = sbr_port_req_i.ar.id;
    mgr_port_req_o.ar.addr   = mgr_ar_addr_i;
    mgr_port_req_o.ar.len    = sbr_port_req_i.ar.len;
    mgr_port_req_o.ar.size   = sbr_port_req_i.ar.size;
    mgr_port_req_o.ar.burst  = sbr_port_req_i.ar.burst;
    mgr_port_req_o.ar.lock   = sbr_port_req_i.ar.lock;
    mgr_port_req_o.ar.cache  = sbr_port_req_i.ar.cache;
    mgr_port_req_o.ar.prot   = sbr_port_req_i.ar.prot;
    mgr_port_req_o.ar.qos    = sbr_port_req_i.ar.qos;
    mgr_port_req_o.ar.region = sbr_port_req_i.ar.region;
    mgr_port_req_o.ar.user   = sbr_port_req_i.ar.user;
    mgr_port_req_o.ar_valid  = sbr_port_req_i.ar_valid;

    mgr_port_req_o.r_ready = sbr_port_req_i.r_ready;
  end

  // Readies, B and R return as they are
  assign sbr_port_rsp_o = mgr_port_rsp_i;

endmodule

// File: design/axi_addr_map_lookup.sv
// Priority address remap lookup
module axi_addr_map_lookup #(
  parameter int unsigned NumRules = axi_remap_pkg::NumRulesDefault
) (
  // Address from the subordinate port
  input  axi_remap_pkg::addr_t                     addr_i,
  // Rule set from the table
  input  axi_remap_pkg::map_rule_t [NumRules-1:0]  rules_i,
  // Translated address, or addr_i on a miss
  output axi_remap_pkg::addr_t                     addr_o,
  // High while no valid rule matches
  output logic                                     miss_o
);

  import axi_remap_pkg::*;

  localparam int unsigned IdxWidth = (NumRules > 1) ? $clog2(NumRules) : 1;

  // One hit bit per rule
  logic [NumRules-1:0] match;
  // Lowest matching index
  logic [IdxWidth-1:0] sel_idx;
  logic                hit;
  map_rule_t           sel_rule;
  addr_t               keep_bits;
  addr_t               new_bits;

  // Per-rule compare under the mask
  for (genvar i = 0; i < NumRules; i++) begin : gen_match
    assign match[i] = rules_i[i].valid &&
                      ((addr_i & rules_i[i].mask) == (rules_i[i].base & rules_i[i].mask));
  end

  assign hit = |match;

  // Scan from the top down so the lowest index is the last one written
  always_comb begin
    sel_idx = '0;
    for (int i = NumRules - 1; i >= 0; i--) begin
      if (match[i]) begin
        sel_idx = IdxWidth'(i);
      end
    end
  end

  assign sel_rule = rules_i[sel_idx];

  // Bits outside the mask stay from the request
  assign keep_bits = addr_i & ~sel_rule.mask;
  // Bits under the mask come from the target
  assign new_bits  = sel_rule.target & sel_rule.mask;

  // Miss leaves the address untouched
  assign addr_o = hit ? (keep_bits | new_bits) : addr_i;
  assign miss_o = ~hit;

endmodule

// File: design/axi_map_rule_table.sv
// Remap rule register table
module axi_map_rule_table #(
  parameter int unsigned NumRules = axi_remap_pkg::NumRulesDefault
) (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  // Config write port
  input  logic                                     cfg_we_i,
  input  logic [$clog2(NumRules)-1:0]              cfg_idx_i,
  input  axi_remap_pkg::map_rule_t                 cfg_rule_i,
  // Current rule set for the lookups
  output axi_remap_pkg::map_rule_t [NumRules-1:0]  rules_o
);

  import axi_remap_pkg::*;

  // Rule storage
  map_rule_t [NumRules-1:0] rules_q;

  // Reset invalidates every rule
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NumRules; i++) begin
        rules_q[i].valid <= 1'b0;
      end
    end else if (cfg_we_i) begin
      // Whole entry replaced in one strobe
      rules_q[cfg_idx_i] <= cfg_rule_i;
    end
  end

  // New rule visible to the lookups the cycle after the write edge
  assign rules_o = rules_q;

  // Config index must address a real entry
  // Only reachable when NumRules is not a power of two
  property p_cfg_idx_in_range;
    @(posedge clk_i) disable iff (!rst_n_i)
      cfg_we_i |-> (int'(cfg_idx_i) < int'(NumRules));
  endproperty

  a_cfg_idx_in_range: assert property (p_cfg_idx_in_range)
    else $error("rule table write to index %0d beyond %0d rules", cfg_idx_i, NumRules);

  // A valid rule must keep base and target inside its mask
  // Lookups compare and merge only under the mask, so stray bits would
  // silently disagree with what software programmed
  property p_rule_bits_in_mask;
    @(posedge clk_i) disable iff (!rst_n_i)
      (cfg_we_i && cfg_rule_i.valid) |->
        (((cfg_rule_i.base & ~cfg_rule_i.mask) == '0) &&
         ((cfg_rule_i.target & ~cfg_rule_i.mask) == '0));
  endproperty

  a_rule_bits_in_mask: assert property (p_rule_bits_in_mask)
    else $error("rule %0d has base or target bits outside its mask", cfg_idx_i);

endmodule

// File: design/axi_remap_pkg.sv
// AXI address remap types
package axi_remap_pkg;

  // Port widths, shared by the subordinate and the manager side
  parameter int unsigned AddrWidth = 32;
  parameter int unsigned DataWidth = 64;
  parameter int unsigned IdWidth   = 4;
  parameter int unsigned UserWidth = 1;
  parameter int unsigned StrbWidth = DataWidth / 8;

  // Rule count when the top level does not override it
  parameter int unsigned NumRulesDefault = 4;

  // Field vectors
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [UserWidth-1:0] user_t;

  // AXI4 control field encodings
  typedef logic [7:0] len_t;
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;
  typedef logic [3:0] cache_t;
  typedef logic [2:0] prot_t;
  typedef logic [3:0] qos_t;
  typedef logic [3:0] region_t;
  typedef logic [5:0] atop_t;
  typedef logic [1:0] resp_t;

  // Write address channel, atop carries atomic operations
  typedef struct packed {
    id_t     id;
    addr_t   addr;
    len_t    len;
    size_t   size;
    burst_t  burst;
    logic    lock;
    cache_t  cache;
    prot_t   prot;
    qos_t    qos;
    region_t region;
    atop_t   atop;
    user_t   user;
  } aw_chan_t;

  // Write data channel
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
    user_t user;
  } w_chan_t;

  // Write response channel
  typedef struct packed {
    id_t   id;
    resp_t resp;
    user_t user;
  } b_chan_t;

  // Read address channel, same as AW without atop
  typedef struct packed {
    id_t     id;
    addr_t   addr;
    len_t    len;
    size_t   size;
    burst_t  burst;
    logic    lock;
    cache_t  cache;
    prot_t   prot;
    qos_t    qos;
    region_t region;
    user_t   user;
  } ar_chan_t;

  // Read data channel
  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
    user_t user;
  } r_chan_t;

  // Manager to subordinate bundle
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Subordinate to manager bundle
  typedef struct packed {
    logic    aw_ready;
    logic    ar_ready;
    logic    w_ready;
    logic    b_valid;
    b_chan_t b;
    logic    r_valid;
    r_chan_t r;
  } axi_rsp_t;

  // One remap rule, match when (addr & mask) == base
  typedef struct packed {
    logic  valid;
    addr_t base;
    addr_t mask;
    addr_t target;
  } map_rule_t;

endpackage
